//--- dprx_ctl.sv
`timescale 1ns/1ns

module dprx_ctl import dprx_pkg::*;
#(
    parameter int P_LANES = 4                       // Lanes built into the link
)
(
    input  logic                LNK_CLK_IN,
    input  logic                arst_n,

    // Wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack,

    // Status from the result stage
    input  logic                lnk_lock,
    input  logic [SYM_W-1:0]    lnk_vbid,

    // Controls to the lane stages
    output lnk_ctl_t            ctl,
    output logic [P_LANES-1:0]  lane_en
);

    logic                 req;                      // New request this cycle
    logic [WB_DAT_W-1:0]  rd_dat;                   // Read mux
    logic [MAX_LANES-1:0] lane_msk;                 // Mask before clipping

    // Ack in flight blocks a second one
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Register read mux
    always_comb
    begin
        case (wb_adr)
            REG_CTRL: rd_dat = {{(WB_DAT_W-$bits(lnk_ctl_t)){1'b0}}, ctl};
            REG_STAT: rd_dat = {lnk_vbid, {(WB_DAT_W-SYM_W-1){1'b0}}, lnk_lock};
            default:  rd_dat = '0;                  // Unmapped reads as zero
        endcase
    end

    // Single cycle classic handshake
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            ctl      <= '0;
        end
        else
        begin
            wb_ack <= req;
            if (req)
            begin
                wb_dat_o <= rd_dat;                 // Valid with ack
                if (wb_we && (wb_adr == REG_CTRL))
                    ctl <= lnk_ctl_t'(wb_dat_i[$bits(lnk_ctl_t)-1:0]);
            end
            else
                wb_dat_o <= '0;
        end
    end

    // Lanes code to mask, full width first
    always_comb
    begin
        case (ctl.lanes)
            2'd1:    lane_msk = MAX_LANES'(4'b0001);
            2'd2:    lane_msk = MAX_LANES'(4'b0011);
            2'd3:    lane_msk = MAX_LANES'(4'b1111);
            default: lane_msk = '0;                 // Code 0, no lane
        endcase
        if (!ctl.en)
            lane_msk = '0;                          // Link off
    end

    assign lane_en = lane_msk[P_LANES-1:0];         // Clip to built lanes

endmodule

//--- dprx_lnk.sv
`timescale 1ns/1ns

module dprx_lnk import dprx_pkg::*;
#(
    parameter int P_LANES = 4                       // 1 to 4 lanes
)
(
    input  logic                        LNK_CLK_IN,
    input  logic                        arst_n,

    // Wishbone classic slave
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic      [WB_ADR_W-1:0]    wb_adr,
    input  logic      [WB_DAT_W-1:0]    wb_dat_i,
    output logic      [WB_DAT_W-1:0]    wb_dat_o,
    output logic                        wb_ack,

    // Link stream
    input  lane_sym_t [P_LANES-1:0]     lnk_in,
    output pars_sym_t [P_LANES-1:0]     lnk_out,
    output logic                        lnk_lock,
    output logic                        lnk_sync,
    output logic      [SYM_W-1:0]       lnk_vbid
);

    lnk_ctl_t                  ctl;                 // CTRL register
    logic      [P_LANES-1:0]   lane_en;             // Active lanes
    pars_sym_t [P_LANES-1:0]   pars_q;              // Parser outputs
    pars_sym_t [P_LANES-1:0]   scrm_q;              // Descrambler outputs
    logic      [P_LANES-1:0]   lane_lock;           // Per lane lock

    // Register slave, status fed back from result stage
    dprx_ctl #(
        .P_LANES    (P_LANES)
    ) u_ctl (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .lnk_lock   (lnk_lock),
        .lnk_vbid   (lnk_vbid),
        .ctl        (ctl),
        .lane_en    (lane_en)
    );

    // Per lane decode and descramble
    for (genvar i = 0; i < P_LANES; i++)
    begin : gen_lane
        dprx_pars u_pars (
            .LNK_CLK_IN (LNK_CLK_IN),
            .arst_n     (arst_n),
            .en         (lane_en[i]),
            .sym_in     (lnk_in[i]),
            .sym_out    (pars_q[i])
        );

        dprx_scrm u_scrm (
            .LNK_CLK_IN (LNK_CLK_IN),
            .arst_n     (arst_n),
            .en         (lane_en[i]),
            .scrm_en    (ctl.scrm_en),      // Shared by all lanes
            .sym_in     (pars_q[i]),
            .sym_out    (scrm_q[i]),
            .lock       (lane_lock[i])
        );
    end

    // Lane merge and link status
    dprx_lnk_res #(
        .P_LANES    (P_LANES)
    ) u_res (
        .LNK_CLK_IN (LNK_CLK_IN),
        .arst_n     (arst_n),
        .lane_en    (lane_en),
        .lane_lock  (lane_lock),
        .sym_in     (scrm_q),
        .lnk_out    (lnk_out),
        .lnk_lock   (lnk_lock),
        .lnk_sync   (lnk_sync),
        .lnk_vbid   (lnk_vbid)
    );

endmodule

//--- dprx_lnk_assertions.sv
`timescale 1ns/1ns

module dprx_lnk_assertions import dprx_pkg::*;
#(
    parameter int P_LANES = 4
)
(
    input logic                    LNK_CLK_IN,
    input logic                    arst_n,
    input logic                    wb_ack,
    input logic      [P_LANES-1:0] lane_en,
    input pars_sym_t [P_LANES-1:0] lnk_out,
    input logic                    lnk_lock,
    input logic                    lnk_sync,
    input logic      [SYM_W-1:0]   lnk_vbid
);

    // Classic slave, one ack per request
    ack_single: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high in two consecutive cycles");

    // Lock is registered, so it drops one cycle after the last lane goes
    lock_needs_lane: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n)
        (lane_en == '0) |=> !lnk_lock)
        else $error("lnk_lock high with no lane enabled");

    // Sync aligned with the lane 0 BS
    sync_on_bs: assert property (@(posedge LNK_CLK_IN) disable iff (!arst_n)
        lnk_sync |-> lnk_out[0].bs)
        else $error("lnk_sync without BS on lane 0");

    // Quiet outputs in reset
    reset_quiet: assert property (@(posedge LNK_CLK_IN)
        !arst_n |-> (lnk_out == '0 && !lnk_lock && !lnk_sync && lnk_vbid == '0 && !wb_ack))
        else $error("output active during reset");

endmodule

//--- dprx_lnk_res.sv
`timescale 1ns/1ns

module dprx_lnk_res import dprx_pkg::*;
#(
    parameter int P_LANES = 4
)
(
    input  logic                        LNK_CLK_IN,
    input  logic                        arst_n,

    input  logic      [P_LANES-1:0]     lane_en,    // Active lane mask
    input  logic      [P_LANES-1:0]     lane_lock,  // Per lane descrambler lock
    input  pars_sym_t [P_LANES-1:0]     sym_in,     // From descramblers

    output pars_sym_t [P_LANES-1:0]     lnk_out,
    output logic                        lnk_lock,
    output logic                        lnk_sync,
    output logic      [SYM_W-1:0]       lnk_vbid
);

    logic all_lock;                             // Every enabled lane locked

    // Disabled lanes count as locked, but one lane must be on
    assign all_lock = (&(lane_lock | ~lane_en)) && (|lane_en);

    // Lane symbol register
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            lnk_out <= '0;
        else
        begin
            for (int i = 0; i < P_LANES; i++)
            begin
                if (lane_en[i])
                    lnk_out[i] <= sym_in[i];
                else
                    lnk_out[i] <= '0;           // Quiet lane
            end
        end
    end

    // Link status, aligned with lnk_out
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lnk_lock <= 1'b0;
            lnk_sync <= 1'b0;
            lnk_vbid <= '0;
        end
        else
        begin
            lnk_lock <= all_lock;
            lnk_sync <= lane_en[0] && sym_in[0].bs;     // One cycle per BS
            if (lane_en[0] && sym_in[0].vbid)
                lnk_vbid <= sym_in[0].dat;              // Held until next VB-ID
        end
    end

endmodule

//--- dprx_pars.sv
`timescale 1ns/1ns

module dprx_pars import dprx_pkg::*;
(
    input  logic      LNK_CLK_IN,
    input  logic      arst_n,

    input  logic      en,                   // Lane enable
    input  lane_sym_t sym_in,               // Raw symbol
    output pars_sym_t sym_out               // Decoded symbol
);

    logic is_bs;                            // K28.5
    logic is_be;                            // K27.7
    logic is_sr;                            // K28.0
    logic in_vid;                           // Between BE and BS
    logic bs_seen;                          // Waiting for VB-ID

    // Control symbol match
    assign is_bs = sym_in.k && (sym_in.dat == K_BS);
    assign is_be = sym_in.k && (sym_in.dat == K_BE);
    assign is_sr = sym_in.k && (sym_in.dat == K_SR);

    // Framing state
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_vid  <= 1'b0;
            bs_seen <= 1'b0;
        end
        else if (!en)
        begin
            in_vid  <= 1'b0;                // Lane off, start clean
            bs_seen <= 1'b0;
        end
        else
        begin
            if (is_be)
                in_vid <= 1'b1;             // Video follows BE
            else if (is_bs)
                in_vid <= 1'b0;

            if (is_bs)
                bs_seen <= 1'b1;
            else if (!sym_in.k)
                bs_seen <= 1'b0;            // VB-ID taken
        end
    end

    // Decoded output register
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            sym_out <= '0;
        else if (!en)
            sym_out <= '0;
        else
        begin
            sym_out.k    <= sym_in.k;
            sym_out.dat  <= sym_in.dat;
            sym_out.bs   <= is_bs;
            sym_out.sr   <= is_sr;
            sym_out.vid  <= in_vid && !sym_in.k;    // Data inside video only
            sym_out.vbid <= bs_seen && !sym_in.k;   // First data after BS
        end
    end

endmodule

//--- dprx_pkg.sv
package dprx_pkg;

    // Link geometry
    localparam int MAX_LANES = 4;               // Widest link supported
    localparam int SYM_W     = 8;               // Symbol width

    // Control symbol codes, K flag set
    localparam logic [SYM_W-1:0] K_BS = 8'hbc;  // K28.5 blanking start
    localparam logic [SYM_W-1:0] K_BE = 8'hfb;  // K27.7 blanking end
    localparam logic [SYM_W-1:0] K_SR = 8'h1c;  // K28.0 scrambler reset

    // Descrambler state loaded on every SR
    localparam logic [15:0] LFSR_SEED = 16'hffff;

    // Wishbone geometry
    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 16;

    // Register map
    localparam logic [WB_ADR_W-1:0] REG_CTRL = 2'd0;   // Link controls, bits 3:0
    localparam logic [WB_ADR_W-1:0] REG_STAT = 2'd1;   // Lock bit 0, VB-ID bits 15:8

    // Link controls, CTRL register image
    typedef struct packed {
        logic       en;                         // Link enable
        logic [1:0] lanes;                      // 1 one lane, 2 two, 3 four, 0 none
        logic       scrm_en;                    // Descrambler enable
    } lnk_ctl_t;

    // Raw lane symbol
    typedef struct packed {
        logic             k;                    // Control symbol
        logic [SYM_W-1:0] dat;
    } lane_sym_t;

    // Decoded lane symbol
    // Carried unchanged from parser through descrambler,
    // only dat is altered by the descrambler
    typedef struct packed {
        logic             k;
        logic [SYM_W-1:0] dat;
        logic             bs;                   // Blanking start
        logic             sr;                   // Scrambler reset
        logic             vid;                  // Active video data
        logic             vbid;                 // VB-ID position
    } pars_sym_t;

endpackage

//--- dprx_scrm.sv
`timescale 1ns/1ns

module dprx_scrm import dprx_pkg::*;
(
    input  logic      LNK_CLK_IN,
    input  logic      arst_n,

    input  logic      en,                       // Lane enable
    input  logic      scrm_en,                  // Descrambling on
    input  pars_sym_t sym_in,                   // From parser
    output pars_sym_t sym_out,                  // Descrambled symbol
    output logic      lock                      // Lane lock
);

    // Galois taps for x^16+x^5+x^4+x^3+1
    localparam logic [15:0] LFSR_TAPS = 16'h0039;

    logic [15:0]      lfsr_q;                   // Current LFSR state
    logic [15:0]      lfsr_nxt;                 // State after eight steps
    logic [SYM_W-1:0] key;                      // Keystream byte
    logic             lock_q;                   // SR seen since enable

    // Eight serial steps per symbol, bit 0 first
    always_comb
    begin
        lfsr_nxt = lfsr_q;
        key      = '0;
        for (int i = 0; i < SYM_W; i++)
        begin
            key[i]   = lfsr_nxt[15];            // Output bit before shift
            lfsr_nxt = {lfsr_nxt[14:0], 1'b0} ^ (lfsr_nxt[15] ? LFSR_TAPS : 16'h0000);
        end
    end

    // LFSR and lock tracking
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lfsr_q <= LFSR_SEED;
            lock_q <= 1'b0;
        end
        else if (!en)
        begin
            lfsr_q <= LFSR_SEED;
            lock_q <= 1'b0;                     // Relock after enable
        end
        else if (sym_in.sr)
        begin
            lfsr_q <= LFSR_SEED;                // Realign on SR
            lock_q <= 1'b1;
        end
        else
            lfsr_q <= lfsr_nxt;                 // Also steps on K symbols
    end

    // Output register
    always_ff @(posedge LNK_CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            sym_out <= '0;
        else if (!en)
            sym_out <= '0;
        else
        begin
            sym_out <= sym_in;                  // Flags pass through
            if (scrm_en && !sym_in.k && !sym_in.sr)
                sym_out.dat <= sym_in.dat ^ key;
        end
    end

    // Without scrambling the lane counts as locked while enabled
    assign lock = scrm_en ? lock_q : en;

endmodule

//--- list.f
dprx_pkg.sv
dprx_ctl.sv
dprx_pars.sv
dprx_scrm.sv
dprx_lnk_res.sv
dprx_lnk.sv
dprx_lnk_assertions.sv
tb_dprx_lnk.sv

//--- tb_dprx_lnk.sv
`timescale 1ns/1ns

module tb_dprx_lnk import dprx_pkg::*;
();

    localparam int        P_LANES = 4;
    localparam int        TIMEOUT = 5000;               // Tests need about 750 cycles
    localparam lane_sym_t FILL    = {1'b1, 8'h00};      // Filler K symbol, no framing meaning

    logic                    LNK_CLK_IN;
    logic                    arst_n;
    logic                    wb_cyc, wb_stb, wb_we;
    logic [WB_ADR_W-1:0]     wb_adr;
    logic [WB_DAT_W-1:0]     wb_dat_i, wb_dat_o;
    logic                    wb_ack;
    lane_sym_t [P_LANES-1:0] lnk_in;
    pars_sym_t [P_LANES-1:0] lnk_out;
    logic                    lnk_lock, lnk_sync;
    logic [SYM_W-1:0]        lnk_vbid;

    // Reference model state, one entry per lane
    logic             st_vid  [P_LANES];
    logic             st_bs   [P_LANES];
    logic [15:0]      st_lfsr [P_LANES];
    logic             st_lock [P_LANES];
    lnk_ctl_t         ctl_model;
    logic [SYM_W-1:0] vbid_model;
    logic             lock_model;

    // Expected values ring, written 3 cycles ahead of the compare
    pars_sym_t [P_LANES-1:0] ring_out  [8];
    logic                    ring_lock [8];
    logic                    ring_sync [8];
    logic [SYM_W-1:0]        ring_vbid [8];
    logic                    ring_v    [8];

    int unsigned             cyc;                       // Cycle counter
    int                      settle;                    // Unchecked cycles after CTRL change
    integer                  seed;
    logic                    wb_done;
    logic [WB_DAT_W-1:0]     rd_last;
    string                   test_name;

    dprx_lnk #(.P_LANES(P_LANES)) dut (.*);

    bind dprx_lnk dprx_lnk_assertions #(.P_LANES(P_LANES)) u_assert (
        .LNK_CLK_IN (LNK_CLK_IN), .arst_n (arst_n), .wb_ack (wb_ack), .lane_en (lane_en),
        .lnk_out (lnk_out), .lnk_lock (lnk_lock), .lnk_sync (lnk_sync), .lnk_vbid (lnk_vbid));

    initial
    begin
        LNK_CLK_IN = 1'b0;
        forever #10 LNK_CLK_IN = ~LNK_CLK_IN;   // 20 ns period
    end

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_sym(input string name, input pars_sym_t exp, input pars_sym_t act);
        if (exp !== act)
            stop_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_fail($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [SYM_W-1:0] exp,
                              input logic [SYM_W-1:0] act);
        if (exp !== act)
            stop_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [WB_DAT_W-1:0] exp,
                              input logic [WB_DAT_W-1:0] act);
        if (exp !== act)
            stop_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    // Active lanes from the CTRL image
    function automatic logic [P_LANES-1:0] lane_mask(input lnk_ctl_t c);
        if (!c.en)
            return '0;
        case (c.lanes)
            2'd1:    return 4'b0001;
            2'd2:    return 4'b0011;
            2'd3:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    // Expected lnk_out symbol of one lane, advances that lane's model state
    function automatic pars_sym_t ref_lane(input int ln, input lane_sym_t s,
                                           input lnk_ctl_t c, input logic en);
        pars_sym_t   o;
        logic [7:0]  key;
        logic [15:0] st;
        logic        fb;
        if (!en)
        begin
            st_vid[ln]  = 1'b0;
            st_bs[ln]   = 1'b0;
            st_lfsr[ln] = LFSR_SEED;
            st_lock[ln] = 1'b0;
            return '0;
        end
        o.k    = s.k;
        o.dat  = s.dat;
        o.bs   = s.k && s.dat == K_BS;
        o.sr   = s.k && s.dat == K_SR;
        o.vid  = st_vid[ln] && !s.k;
        o.vbid = st_bs[ln] && !s.k;
        if (s.k && s.dat == K_BE)
            st_vid[ln] = 1'b1;
        else if (o.bs)
            st_vid[ln] = 1'b0;
        if (o.bs)
            st_bs[ln] = 1'b1;
        else if (!s.k)
            st_bs[ln] = 1'b0;
        // x^16+x^5+x^4+x^3+1, output is the top bit, eight steps per symbol
        st = st_lfsr[ln];
        for (int b = 0; b < 8; b++)
        begin
            fb     = st[15];
            key[b] = fb;
            st     = st << 1;
            if (fb)
                st = st ^ 16'h0039;
        end
        if (o.sr)
        begin
            st_lfsr[ln] = LFSR_SEED;
            st_lock[ln] = 1'b1;
        end
        else
        begin
            st_lfsr[ln] = st;
            if (c.scrm_en && !s.k)
                o.dat = s.dat ^ key;
        end
        return o;
    endfunction

    // One stream cycle, also finishes a pending Wishbone request
    task automatic tick(input lane_sym_t [P_LANES-1:0] sym);
        pars_sym_t [P_LANES-1:0] e;
        logic [P_LANES-1:0]      en_m;
        logic                    lk;
        int                      w;
        @(negedge LNK_CLK_IN);
        if (wb_stb && wb_ack)
        begin
            rd_last = wb_dat_o;
            if (wb_we && wb_adr == REG_CTRL)
            begin
                ctl_model = lnk_ctl_t'(wb_dat_i[3:0]);
                settle    = 3;                      // Pipeline stages see the change apart
                ring_v[(cyc + 1) % 8] = 1'b0;
                ring_v[(cyc + 2) % 8] = 1'b0;
            end
            wb_cyc  = 1'b0;
            wb_stb  = 1'b0;
            wb_we   = 1'b0;
            wb_done = 1'b1;
        end
        lnk_in = sym;
        en_m   = lane_mask(ctl_model);
        lk     = |en_m;
        for (int i = 0; i < P_LANES; i++)
        begin
            e[i] = ref_lane(i, sym[i], ctl_model, en_m[i]);
            if (en_m[i] && ctl_model.scrm_en && !st_lock[i])
                lk = 1'b0;
        end
        if (en_m[0] && e[0].vbid)
            vbid_model = e[0].dat;
        w = (cyc + 3) % 8;
        ring_out[w]  = e;
        ring_lock[w] = lk;
        ring_sync[w] = en_m[0] && e[0].bs;
        ring_vbid[w] = vbid_model;
        ring_v[w]    = (settle == 0);
        if (settle > 0)
            settle--;
        lock_model = lk;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) tick({P_LANES{FILL}});
    endtask

    task automatic bus_write(input logic [WB_ADR_W-1:0] a, input logic [WB_DAT_W-1:0] d);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = a;
        wb_dat_i = d;
        wb_done  = 1'b0;
        while (!wb_done)
            tick({P_LANES{FILL}});
    endtask

    task automatic bus_read(input logic [WB_ADR_W-1:0] a, output logic [WB_DAT_W-1:0] d);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = 1'b0;
        wb_adr  = a;
        wb_done = 1'b0;
        while (!wb_done)
            tick({P_LANES{FILL}});
        d = rd_last;
    endtask

    // Mostly data, sometimes a framing K code
    function automatic lane_sym_t rand_sym();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] != 4'd0)
            return {1'b0, r[15:8]};
        case (r[5:4])
            2'd0:    return {1'b1, K_BS};
            2'd1:    return {1'b1, K_BE};
            2'd2:    return {1'b1, K_SR};
            default: return FILL;
        endcase
    endfunction

    // Cycle count and timeout
    always @(posedge LNK_CLK_IN)
    begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT)
            stop_fail($sformatf("Timeout after %0d cycles, tests did not finish", TIMEOUT));
    end

    // Compare DUT outputs against the delayed reference
    always @(negedge LNK_CLK_IN)
    begin : compare
        int k;
        k = cyc % 8;
        if (ring_v[k])
        begin
            for (int i = 0; i < P_LANES; i++)
                check_sym($sformatf("%s lane %0d", test_name, i), ring_out[k][i], lnk_out[i]);
            check_bit({test_name, " lock"}, ring_lock[k], lnk_lock);
            check_bit({test_name, " sync"}, ring_sync[k], lnk_sync);
            check_byte({test_name, " vbid"}, ring_vbid[k], lnk_vbid);
        end
    end

    initial
    begin : stim
        logic [WB_DAT_W-1:0]     d;
        lane_sym_t [P_LANES-1:0] s;
        seed = 32'h2edacef8;
        arst_n = 1'b0;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr = '0;
        wb_dat_i = '0;
        lnk_in = {P_LANES{FILL}};
        cyc = 0;
        settle = 0;
        wb_done = 1'b0;
        rd_last = '0;
        ctl_model = '0;
        vbid_model = '0;
        lock_model = 1'b0;
        test_name = "reset";
        for (int i = 0; i < 8; i++)
            ring_v[i] = 1'b0;
        for (int i = 0; i < P_LANES; i++)
        begin
            st_vid[i] = 1'b0;
            st_bs[i] = 1'b0;
            st_lfsr[i] = LFSR_SEED;
            st_lock[i] = 1'b0;
        end
        repeat (16) @(posedge LNK_CLK_IN);
        @(negedge LNK_CLK_IN);
        arst_n = 1'b1;

        test_name = "registers";
        bus_read(REG_CTRL, d);
        check_word("ctrl after reset", 16'h0000, d);
        bus_read(REG_STAT, d);
        check_word("stat after reset", 16'h0000, d);
        bus_write(REG_CTRL, 16'hfff6);              // Only bits 3:0 stored
        bus_read(REG_CTRL, d);
        check_word("ctrl readback", 16'h0006, d);
        bus_read(2'd2, d);
        check_word("unmapped read", 16'h0000, d);

        test_name = "four lanes";
        bus_write(REG_CTRL, 16'h000f);
        idle_cycles(4);
        tick({P_LANES{{1'b1, K_SR}}});
        for (int n = 0; n < 300; n++)
        begin
            for (int i = 0; i < P_LANES; i++)
                s[i] = rand_sym();
            tick(s);
        end
        idle_cycles(4);
        check_bit("four lanes lock", 1'b1, lnk_lock);

        test_name = "two lanes";
        bus_write(REG_CTRL, 16'h0000);
        idle_cycles(4);
        bus_write(REG_CTRL, 16'h000d);
        idle_cycles(6);
        check_bit("two lanes unlocked", 1'b0, lnk_lock);
        tick({FILL, FILL, {1'b1, K_SR}, {1'b1, K_SR}});
        for (int n = 0; n < 150; n++)
        begin
            for (int i = 0; i < P_LANES; i++)
                s[i] = rand_sym();
            tick(s);
        end
        idle_cycles(4);
        check_bit("two lanes lock", 1'b1, lnk_lock);

        test_name = "framing";
        bus_write(REG_CTRL, 16'h000f);
        idle_cycles(4);
        tick({P_LANES{{1'b1, K_SR}}});
        tick({P_LANES{{1'b1, K_BE}}});
        tick({P_LANES{rand_sym() & 9'h0ff}});       // Video data after BE
        tick({P_LANES{{1'b1, K_BS}}});
        tick({P_LANES{rand_sym() & 9'h0ff}});       // VB-ID byte
        tick({P_LANES{rand_sym() & 9'h0ff}});
        idle_cycles(5);
        check_byte("framing vbid", vbid_model, lnk_vbid);
        bus_read(REG_STAT, d);
        check_word("framing stat", {vbid_model, 7'b0, lock_model}, d);

        test_name = "no scrambling";
        bus_write(REG_CTRL, 16'h000e);
        idle_cycles(4);
        for (int n = 0; n < 200; n++)
        begin
            for (int i = 0; i < P_LANES; i++)
                s[i] = rand_sym();
            tick(s);
        end
        check_bit("no scrambling lock", 1'b1, lnk_lock);
        bus_write(REG_CTRL, 16'h0000);              // Link off
        idle_cycles(5);
        check_bit("disabled lock", 1'b0, lnk_lock);
        for (int i = 0; i < P_LANES; i++)
            check_sym($sformatf("disabled lane %0d", i), '0, lnk_out[i]);

        $display("Test completed successfully");
        $finish;
    end

endmodule
